// File: sim.f
crop_pkg.sv
crop_regs.sv
hblank_gen.sv
vblank_gen.sv
frame_monitor.sv
video_crop.sv
video_crop_asserts.sv
tb_clock.sv
tb_video_crop.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_video_crop -f sim.f -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_video_crop.sv
/*
 * Screen crop testbench
 * Raster generator, AXI4-Lite master tasks and directed tests
 */
`default_nettype none

module tb_video_crop
	import crop_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINE_CYC    = 200; // Two cycles per pixel count
	localparam int HS_CYC      = 20;
	localparam int HB_FALL_CYC = 60;
	localparam int ACT_W       = 48;  // Active width in pixels
	localparam int ACT_W2      = 40;
	localparam int FRAME_LINES = 24;
	localparam int VBL_LINES   = 6;   // vblank on lines 0..5
	localparam int VS_FIRST    = 1;
	localparam int VS_LAST     = 2;
	localparam int HOLD_CYC    = 3;
	localparam int HS_TIMEOUT  = 50;
	localparam int TEST_FRAMES = 20;
	localparam int WATCHDOG_NS = (TEST_FRAMES + 10) * FRAME_LINES * LINE_CYC * 8;
	// Start line count is registered as the first active line's increment lands
	localparam int V_START = VBL_LINES - 1;
	localparam int V_MAX   = FRAME_LINES - 1;

	logic      clk_sys, reset;
	logic      s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready;
	logic      s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
	axi_addr_t s_awaddr, s_araddr;
	axi_data_t s_wdata, s_rdata;
	axi_resp_t s_bresp, s_rresp;
	logic      hs_n, vs_n, hblank, vblank;
	logic      hde, vde, de;

	logic      raster_on;
	int        act_w;
	int        errors;
	int        line_hde, last_hde;
	int        frame_de, last_frame_de;
	int        frame_vde, last_frame_vde;
	int        frame_lines, last_frame_lines;
	logic      line_had_de, prev_hs_n, prev_vblank;

	tb_clock u_clock (.clk_sys(clk_sys), .reset(reset));

	video_crop DUT (.*);

	bind video_crop video_crop_asserts u_asserts (
		.clk_sys(clk_sys), .reset(reset),
		.s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata),
		.hs_n(hs_n), .hde(hde)
	);

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(string name, axi_data_t exp, axi_data_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_coord(string name, coord_t exp, coord_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(string name, chg_cnt_t exp, chg_cnt_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_resp(string name, axi_resp_t exp, axi_resp_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic handshake_timeout(string what);
		errors++;
		$display("No %s handshake within %0d cycles at %0t", what, HS_TIMEOUT, $time);
		abort_run();
	endtask

	task automatic axi_write(axi_addr_t addr, axi_data_t data);
		int n;
		s_awvalid = 1'b1; // Address alone is not taken
		s_awaddr  = addr;
		s_wdata   = data;
		@(posedge clk_sys);
		check_flag("s_awready", 1'b0, s_awready);
		check_flag("s_wready", 1'b0, s_wready);
		#1 s_wvalid = 1'b1;
		n = 0;
		@(posedge clk_sys);
		while (!(s_awready && s_wready)) begin
			if (++n > HS_TIMEOUT) handshake_timeout("write address");
			@(posedge clk_sys);
		end
		repeat (HOLD_CYC) begin // bready held low, valids still up
			@(posedge clk_sys);
			check_flag("s_bvalid", 1'b1, s_bvalid);
			check_flag("s_awready", 1'b0, s_awready);
			check_flag("s_wready", 1'b0, s_wready);
			check_flag("s_arready", 1'b1, s_arready); // Read side stays free
		end
		#1;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b1;
		@(posedge clk_sys);
		check_resp("s_bresp", RESP_OKAY, s_bresp);
		#1 s_bready = 1'b0;
	endtask

	task automatic axi_read(axi_addr_t addr, output axi_data_t data);
		int n;
		axi_data_t first;
		s_arvalid = 1'b1;
		s_araddr  = addr;
		n = 0;
		@(posedge clk_sys);
		while (!s_arready) begin
			if (++n > HS_TIMEOUT) handshake_timeout("read address");
			@(posedge clk_sys);
		end
		n = 0;
		@(posedge clk_sys);
		while (!s_rvalid) begin
			if (++n > HS_TIMEOUT) handshake_timeout("read data");
			@(posedge clk_sys);
		end
		first = s_rdata;
		repeat (HOLD_CYC) begin // rready held low, arvalid still up
			@(posedge clk_sys);
			check_flag("s_rvalid", 1'b1, s_rvalid);
			check_flag("s_arready", 1'b0, s_arready);
			check_data("s_rdata held", first, s_rdata);
		end
		#1;
		s_arvalid = 1'b0;
		s_rready  = 1'b1;
		@(posedge clk_sys);
		data = s_rdata;
		check_resp("s_rresp", RESP_OKAY, s_rresp);
		#1 s_rready = 1'b0;
	endtask

	task automatic wait_frames(int n);
		repeat (n) @(posedge vblank);
		repeat (2) @(posedge clk_sys); // Let the frame statistics settle
		#1;
	endtask

	// Raster source, line width picked up at the start of each line
	initial begin
		int w;
		hs_n   = 1'b1;
		vs_n   = 1'b1;
		hblank = 1'b1;
		vblank = 1'b1;
		wait (raster_on);
		forever begin
			for (int line = 0; line < FRAME_LINES; line++) begin
				w = act_w;
				for (int c = 0; c < LINE_CYC; c++) begin
					@(posedge clk_sys);
					#1;
					hs_n   = (c >= HS_CYC);
					hblank = !(c >= HB_FALL_CYC && c < HB_FALL_CYC + 2 * w);
					vblank = (line < VBL_LINES);
					vs_n   = !(line >= VS_FIRST && line <= VS_LAST);
				end
			end
		end
	end

	// Per-line hde and per-frame de statistics
	initial begin
		line_hde = 0;
		last_hde = 0;
		frame_de = 0;
		last_frame_de = 0;
		frame_vde = 0;
		last_frame_vde = 0;
		frame_lines = 0;
		last_frame_lines = 0;
		line_had_de = 1'b0;
		prev_hs_n = 1'b1;
		prev_vblank = 1'b1;
		forever begin
			@(posedge clk_sys);
			if (prev_hs_n && !hs_n) begin
				last_hde = line_hde;
				line_hde = 0;
				if (line_had_de) frame_lines++;
				line_had_de = 1'b0;
			end
			if (!prev_vblank && vblank) begin
				last_frame_de    = frame_de;
				last_frame_vde   = frame_vde;
				last_frame_lines = frame_lines;
				frame_de    = 0;
				frame_vde   = 0;
				frame_lines = 0;
			end
			if (hde) line_hde++;
			if (vde) frame_vde++;
			if (de) begin
				frame_de++;
				line_had_de = 1'b1;
			end
			prev_hs_n   = hs_n;
			prev_vblank = vblank;
		end
	end

	task automatic test_registers();
		axi_data_t d;
		check_flag("s_bvalid", 1'b0, s_bvalid);
		check_flag("s_rvalid", 1'b0, s_rvalid);
		check_flag("hde", 1'b0, hde);
		check_flag("vde", 1'b0, vde);
		check_flag("de", 1'b0, de);
		for (int a = 0; a < 16; a += 4) begin
			axi_read(axi_addr_t'(a), d);
			check_data("reset value", 32'h0, d);
		end
		axi_write(REG_CROP_H, 32'hFABC_F123); // Unused bits dropped
		axi_write(REG_CROP_V, 32'h1765_5432);
		axi_write(REG_GEOM, 32'hFFFF_FFFF);
		axi_write(REG_FLAGS, 32'hFFFF_FFFF);
		axi_read(REG_CROP_H, d);
		check_data("CROP_H", 32'h0ABC_0123, d);
		axi_read(REG_CROP_V, d);
		check_data("CROP_V", 32'h0765_0432, d);
		axi_read(REG_GEOM, d);
		check_data("GEOM", 32'h0, d);
		axi_read(REG_FLAGS, d);
		check_data("FLAGS", 32'h0, d);
		axi_write(REG_CROP_H, 32'h0);
		axi_write(REG_CROP_V, 32'h0);
	endtask

	task automatic test_geometry();
		axi_data_t d;
		raster_on = 1'b1;
		wait_frames(4);
		axi_read(REG_GEOM, d);
		check_coord("geom hsize", coord_t'(ACT_W), d[11:0]);
		check_coord("geom vsize", coord_t'(FRAME_LINES - VBL_LINES), d[27:16]);
	endtask

	task automatic test_hcrop(int left, int right);
		axi_write(REG_CROP_H, (right << FIELD_HI_LSB) | left);
		wait_frames(1);
		check_coord("hde cycles per line", coord_t'(2 * (ACT_W + right - left)),
			coord_t'(last_hde));
	endtask

	task automatic test_vcrop(int top, coord_t bottom, int hde_cyc);
		int bot_pos;
		int lines;
		axi_write(REG_CROP_V, (int'(bottom) << FIELD_HI_LSB) | top);
		if (bottom[11])
			bot_pos = (V_MAX + int'(bottom)) % 4096;
		else
			bot_pos = int'(bottom);
		lines = bot_pos - V_START - top;
		wait_frames(2);
		check_coord("de lines per frame", coord_t'(lines), coord_t'(last_frame_lines));
		check_coord("de cycles per frame", coord_t'(lines * hde_cyc),
			coord_t'(last_frame_de));
		// vde spans whole lines, from one line start decision to the next
		check_coord("vde cycles per frame", coord_t'(lines * LINE_CYC),
			coord_t'(last_frame_vde));
	endtask

	task automatic test_changes();
		axi_data_t d;
		chg_cnt_t  base;
		axi_read(REG_FLAGS, d);
		base = d[6:0];
		act_w = ACT_W2;
		wait_frames(2);
		axi_read(REG_GEOM, d);
		check_coord("geom hsize after switch", coord_t'(ACT_W2), d[11:0]);
		act_w = ACT_W;
		wait_frames(2);
		axi_read(REG_FLAGS, d);
		check_count("chg_cnt after two switches", base + chg_cnt_t'(2), d[6:0]);
		base = d[6:0];
		wait_frames(3);
		axi_read(REG_FLAGS, d);
		check_count("chg_cnt steady raster", base, d[6:0]);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		errors    = 0;
		raster_on = 1'b0;
		act_w     = ACT_W;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		s_awaddr  = '0;
		s_araddr  = '0;
		s_wdata   = '0;
		@(negedge reset);
		@(posedge clk_sys);
		#1;
		test_registers();
		test_geometry();
		test_hcrop(4, 6);
		test_vcrop(2, 12'd20, 2 * (ACT_W + 6 - 4));
		test_vcrop(2, 12'hFFC, 2 * (ACT_W + 6 - 4)); // Four lines back from the end
		test_changes();
		if (errors == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: tb_clock.sv
/*
 * Testbench clock and reset
 * 8 ns clock, reset held for the first 4 cycles
 */
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD_NS = 8;

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: video_crop_asserts.sv
/*
 * Screen crop protocol checks
 * Response hold on both AXI channels, no enable during hsync
 */
`default_nettype none

module video_crop_asserts
	import crop_pkg::*;
(
	input wire       clk_sys,
	input wire       reset,
	input wire       s_bvalid,
	input wire       s_bready,
	input wire       s_rvalid,
	input wire       s_rready,
	input axi_data_t s_rdata,
	input wire       hs_n,
	input wire       hde
);
	timeunit 1ns;
	timeprecision 100ps;

	// Write response stays up until taken
	bvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
		s_bvalid && !s_bready |=> s_bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
		else $error("read response changed before rready");

	// hde is registered from a blank that includes hsync
	hde_in_sync: assert property (@(posedge clk_sys) disable iff (reset)
		!hs_n |=> !hde)
		else $error("hde high after an hsync cycle");

endmodule

`default_nettype wire

// File: video_crop.sv
/*
 * Screen crop top level
 * Register block plus horizontal, vertical and frame logic
 */
`default_nettype none

module video_crop
	import crop_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,

	input  wire       s_awvalid,
	output logic      s_awready,
	input  axi_addr_t s_awaddr,
	input  wire       s_wvalid,
	output logic      s_wready,
	input  axi_data_t s_wdata,
	output logic      s_bvalid,
	input  wire       s_bready,
	output axi_resp_t s_bresp,
	input  wire       s_arvalid,
	output logic      s_arready,
	input  axi_addr_t s_araddr,
	output logic      s_rvalid,
	input  wire       s_rready,
	output axi_data_t s_rdata,
	output axi_resp_t s_rresp,

	input  wire       hs_n,
	input  wire       vs_n,
	input  wire       hblank,
	input  wire       vblank,
	output logic      hde,
	output logic      vde,
	output logic      de
);

	coord_t   crop_left;
	coord_t   crop_right;
	coord_t   crop_top;
	coord_t   crop_bottom;
	coord_t   hsize;
	coord_t   vsize;
	coord_t   geom_hsize;
	coord_t   geom_vsize;
	chg_cnt_t chg_cnt;
	logic     hbl;     // Horizontal blank incl. hsync

	crop_regs u_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.s_awvalid   (s_awvalid),
		.s_awready   (s_awready),
		.s_awaddr    (s_awaddr),
		.s_wvalid    (s_wvalid),
		.s_wready    (s_wready),
		.s_wdata     (s_wdata),
		.s_bvalid    (s_bvalid),
		.s_bready    (s_bready),
		.s_bresp     (s_bresp),
		.s_arvalid   (s_arvalid),
		.s_arready   (s_arready),
		.s_araddr    (s_araddr),
		.s_rvalid    (s_rvalid),
		.s_rready    (s_rready),
		.s_rdata     (s_rdata),
		.s_rresp     (s_rresp),
		.geom_hsize  (geom_hsize),
		.geom_vsize  (geom_vsize),
		.chg_cnt     (chg_cnt),
		.crop_left   (crop_left),
		.crop_right  (crop_right),
		.crop_top    (crop_top),
		.crop_bottom (crop_bottom)
	);

	hblank_gen u_hblank (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.hs_n       (hs_n),
		.hblank     (hblank),
		.crop_left  (crop_left),
		.crop_right (crop_right),
		.hde        (hde),
		.hbl        (hbl),
		.hsize      (hsize)
	);

	vblank_gen u_vblank (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.hs_n        (hs_n),
		.vs_n        (vs_n),
		.vblank      (vblank),
		.hbl         (hbl),
		.hde         (hde),
		.crop_top    (crop_top),
		.crop_bottom (crop_bottom),
		.vde         (vde),
		.de          (de),
		.vsize       (vsize)
	);

	frame_monitor u_monitor (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.vblank     (vblank),
		.hsize      (hsize),
		.vsize      (vsize),
		.geom_hsize (geom_hsize),
		.geom_vsize (geom_vsize),
		.chg_cnt    (chg_cnt)
	);

endmodule

`default_nettype wire

// File: frame_monitor.sv
/*
 * Frame geometry monitor
 * Snapshots the active size once per frame and counts changes
 */
`default_nettype none

module frame_monitor
	import crop_pkg::*;
(
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      vblank,
	input  coord_t   hsize,
	input  coord_t   vsize,
	output coord_t   geom_hsize,
	output coord_t   geom_vsize,
	output chg_cnt_t chg_cnt
);

	logic old_vblank;
	logic frame_start;

	assign frame_start = old_vblank && !vblank; // First active line of a frame

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b1;
			geom_hsize <= '0;
			geom_vsize <= '0;
			chg_cnt    <= '0;
		end else begin
			old_vblank <= vblank;
			if (frame_start) begin
				geom_hsize <= hsize;
				geom_vsize <= vsize;
				// One step per changed frame, even if both sizes moved
				if (geom_hsize != hsize || geom_vsize != vsize) begin
					chg_cnt <= chg_cnt + chg_cnt_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: vblank_gen.sv
/*
 * Vertical crop
 * Counts lines, measures the active height and applies
 * top/bottom crop plus the forced vertical border
 */
`default_nettype none

module vblank_gen
	import crop_pkg::*;
(
	input  wire    clk_sys,
	input  wire    reset,
	input  wire    hs_n,
	input  wire    vs_n,
	input  wire    vblank,
	input  wire    hbl,
	input  wire    hde,
	input  coord_t crop_top,
	input  coord_t crop_bottom,
	output logic   vde,
	output logic   de,
	output coord_t vsize
);

	logic   old_hs_n;
	logic   old_vs_n;
	logic   old_vblank;
	logic   old_hbl;
	coord_t vcnt;
	coord_t vstart;   // First active line
	coord_t vmax;     // Last line of the frame
	coord_t vs_end;
	coord_t bot_line;
	logic   svbl;     // Crop blank
	logic   fvbl;     // Forced border blank
	logic   upd;

	// Bit 11 set means the offset counts back from the last line
	assign bot_line = crop_bottom[COORD_W-1] ? vmax + crop_bottom : crop_bottom;

	assign upd = (old_hbl && !hbl) || (vcnt == '0);

	assign vde = ~(fvbl | svbl);
	assign de  = hde & vde;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs_n   <= 1'b1;
			old_vs_n   <= 1'b1;
			old_vblank <= 1'b1;
			old_hbl    <= 1'b1;
			vcnt       <= '0;
			vstart     <= '0;
			vmax       <= '0;
			vs_end     <= '0;
			vsize      <= '0;
			svbl       <= 1'b1;
			fvbl       <= 1'b1;
		end else begin
			old_hs_n   <= hs_n;
			old_vs_n   <= vs_n;
			old_vblank <= vblank;
			old_hbl    <= hbl;

			if (old_hs_n && !hs_n) vcnt <= vcnt + coord_t'(1);
			if (!old_vblank && vblank) begin
				vcnt  <= '0;
				vmax  <= vcnt;
				vsize <= vcnt - vstart;
			end
			if (old_vblank && !vblank) vstart <= vcnt;
			if (!old_vs_n && vs_n)     vs_end <= vcnt;

			// Decisions only at the start of a line
			if (upd) begin
				if (vcnt == vstart + crop_top) svbl <= 1'b0;
				if (vcnt == bot_line)          svbl <= 1'b1;

				if (vcnt == vmax - V_FORCE_LEAD)    fvbl <= 1'b1;
				if (vcnt == vs_end + V_FORCE_TRAIL) fvbl <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hblank_gen.sv
/*
 * Horizontal crop
 * Measures the active part of each line and builds the
 * cropped, border-limited horizontal display enable
 */
`default_nettype none

module hblank_gen
	import crop_pkg::*;
(
	input  wire    clk_sys,
	input  wire    reset,
	input  wire    hs_n,
	input  wire    hblank,
	input  coord_t crop_left,
	input  coord_t crop_right,
	output logic   hde,
	output logic   hbl,
	output coord_t hsize
);

	logic   old_hs_n;
	logic   old_hblank;
	logic   hph;       // Count phase, one step every other cycle
	coord_t hcnt;
	coord_t hsta;
	coord_t hend;
	coord_t hmax;
	logic   shbl;      // Crop blank
	logic   fhbl;      // Forced border blank

	assign hbl = fhbl | shbl | ~hs_n;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs_n   <= 1'b1;
			old_hblank <= 1'b1;
			hph        <= 1'b0;
			hcnt       <= '0;
			hsta       <= '0;
			hend       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
			hde        <= 1'b0;
		end else begin
			old_hs_n   <= hs_n;
			old_hblank <= hblank;

			if (!hs_n) begin
				hcnt <= '0;
				hph  <= 1'b0;
			end else begin
				hph <= ~hph;
				if (hph) hcnt <= hcnt + coord_t'(1);
			end

			if (old_hblank && !hblank) hsta <= hcnt; // Active start
			if (!old_hblank && hblank) begin
				hend  <= hcnt;
				hsize <= hcnt - hsta;
			end
			if (old_hs_n && !hs_n) hmax <= hcnt;    // Line length

			if (hcnt == hsta + crop_left - H_CROP_BIAS)  shbl <= 1'b0;
			if (hcnt == hend + crop_right - H_CROP_BIAS) shbl <= 1'b1;

			if (hcnt == H_FORCE_MARGIN)        fhbl <= 1'b0;
			if (hcnt == hmax - H_FORCE_MARGIN) fhbl <= 1'b1;

			hde <= ~hbl;
		end
	end

endmodule

`default_nettype wire

// File: crop_regs.sv
/*
 * Crop register block
 * AXI4-Lite slave holding the four crop offsets and
 * reporting the measured frame geometry and change count
 */
`default_nettype none

module crop_regs
	import crop_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,

	input  wire        s_awvalid,
	output logic       s_awready,
	input  axi_addr_t  s_awaddr,
	input  wire        s_wvalid,
	output logic       s_wready,
	input  axi_data_t  s_wdata,
	output logic       s_bvalid,
	input  wire        s_bready,
	output axi_resp_t  s_bresp,
	input  wire        s_arvalid,
	output logic       s_arready,
	input  axi_addr_t  s_araddr,
	output logic       s_rvalid,
	input  wire        s_rready,
	output axi_data_t  s_rdata,
	output axi_resp_t  s_rresp,

	input  coord_t     geom_hsize,
	input  coord_t     geom_vsize,
	input  chg_cnt_t   chg_cnt,

	output coord_t     crop_left,
	output coord_t     crop_right,
	output coord_t     crop_top,
	output coord_t     crop_bottom
);

	axi_wstate_t wstate;
	logic        wr_go;
	logic        rd_go;
	axi_data_t   rd_mux;

	// Two 12-bit fields in one word, upper field at bit 16
	function automatic axi_data_t pack_pair(coord_t lo, coord_t hi);
		axi_data_t d;
		d = '0;
		d[COORD_W-1:0] = lo;
		d[FIELD_HI_LSB +: COORD_W] = hi;
		return d;
	endfunction

	// Address and data are taken together, one write in flight
	assign wr_go     = (wstate == W_IDLE) && s_awvalid && s_wvalid;
	assign s_awready = wr_go;
	assign s_wready  = wr_go;
	assign s_bvalid  = (wstate == W_RESP);
	assign s_bresp   = RESP_OKAY;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wstate <= W_IDLE;
		end else begin
			case (wstate)
				W_IDLE: if (wr_go) wstate <= W_RESP;
				W_RESP: if (s_bready) wstate <= W_IDLE;
				default: wstate <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			crop_left   <= '0;
			crop_right  <= '0;
			crop_top    <= '0;
			crop_bottom <= '0;
		end else if (wr_go) begin
			case (s_awaddr)
				REG_CROP_H: begin
					crop_left  <= s_wdata[COORD_W-1:0];
					crop_right <= s_wdata[FIELD_HI_LSB +: COORD_W];
				end
				REG_CROP_V: begin
					crop_top    <= s_wdata[COORD_W-1:0];
					crop_bottom <= s_wdata[FIELD_HI_LSB +: COORD_W];
				end
				default: ; // Read-only or unmapped, dropped
			endcase
		end
	end

	// Read side
	always_comb begin
		case (s_araddr)
			REG_CROP_H: rd_mux = pack_pair(crop_left, crop_right);
			REG_CROP_V: rd_mux = pack_pair(crop_top, crop_bottom);
			REG_GEOM:   rd_mux = pack_pair(geom_hsize, geom_vsize);
			REG_FLAGS:  rd_mux = {{($bits(axi_data_t) - CHG_W){1'b0}}, chg_cnt};
			default:    rd_mux = '0;
		endcase
	end

	assign s_arready = ~s_rvalid; // Free while no response is held
	assign rd_go     = s_arvalid && s_arready;
	assign s_rresp   = RESP_OKAY;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			s_rvalid <= 1'b0;
		end else if (rd_go) begin
			s_rvalid <= 1'b1;
		end else if (s_rready) begin
			s_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_go) s_rdata <= rd_mux;
	end

endmodule

`default_nettype wire

// File: crop_pkg.sv
/*
 * Screen crop shared definitions
 * Widths, register map, handshake states and raster constants
 */
`default_nettype none

package crop_pkg;

	localparam int COORD_W = 12;
	localparam int CHG_W   = 7;

	typedef logic [COORD_W-1:0] coord_t; // Pixel, line or offset
	typedef logic [3:0]         axi_addr_t;
	typedef logic [31:0]        axi_data_t;
	typedef logic [1:0]         axi_resp_t;
	typedef logic [CHG_W-1:0]   chg_cnt_t;

	typedef enum logic {
		W_IDLE,
		W_RESP
	} axi_wstate_t;

	localparam axi_addr_t REG_CROP_H = 4'h0;
	localparam axi_addr_t REG_CROP_V = 4'h4;
	localparam axi_addr_t REG_GEOM   = 4'h8;
	localparam axi_addr_t REG_FLAGS  = 4'hC;
	localparam int        FIELD_HI_LSB = 16;

	localparam coord_t H_FORCE_MARGIN = 12'd8; // Border blanked at both line ends
	localparam coord_t H_CROP_BIAS    = 12'd2; // Compare pipeline correction
	localparam coord_t V_FORCE_LEAD   = 12'd1;
	localparam coord_t V_FORCE_TRAIL  = 12'd2;

	localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
